// ==== src/csr_pkg.sv ====
package csr_pkg;

    localparam int csr_addr_w = 14;
    localparam int csr_data_w = 32;
    localparam int plv_w      = 2;    // Privilege level field

    // Implemented CSR addresses
    localparam logic [csr_addr_w-1:0] csr_crmd   = 14'h0000;
    localparam logic [csr_addr_w-1:0] csr_prmd   = 14'h0001;
    localparam logic [csr_addr_w-1:0] csr_estat  = 14'h0005;
    localparam logic [csr_addr_w-1:0] csr_era    = 14'h0006;
    localparam logic [csr_addr_w-1:0] csr_badv   = 14'h0007;
    localparam logic [csr_addr_w-1:0] csr_eentry = 14'h000c;
    localparam logic [csr_addr_w-1:0] csr_save0  = 14'h0030;

    // CRMD fields
    localparam int crmd_plv_lsb = 0;
    localparam int crmd_ie_bit  = 2;

    // PRMD keeps the pre-exception copy
    localparam int prmd_pplv_lsb = 0;
    localparam int prmd_pie_bit  = 2;

    localparam int estat_ecode_lsb = 16;  // Ecode in ESTAT[22:16]

endpackage

// ==== src/excp_pkg.sv ====
package excp_pkg;

    localparam int ecode_w = 7;
    localparam int vaddr_w = 32;   // PC and bad address width

    // Exception codes as written to ESTAT
    localparam logic [ecode_w-1:0] ecode_none = 7'h00;
    localparam logic [ecode_w-1:0] ecode_adef = 7'h08;  // Fetch address error
    localparam logic [ecode_w-1:0] ecode_ale  = 7'h09;  // Misaligned access
    localparam logic [ecode_w-1:0] ecode_sys  = 7'h0b;
    localparam logic [ecode_w-1:0] ecode_brk  = 7'h0c;
    localparam logic [ecode_w-1:0] ecode_ine  = 7'h0d;  // Undefined instruction
    localparam logic [ecode_w-1:0] ecode_ipe  = 7'h0e;  // Privilege error

endpackage

// ==== src/csr_pipe_if.sv ====
`timescale 1ns/1ns

// MEM stage lane data and the resolved commit decision
interface mem_excp_if;
    import excp_pkg::*;

    logic [ecode_w-1:0] mem_ecode_a;
    logic [ecode_w-1:0] mem_ecode_b;
    logic               mem_ecode_we_a;
    logic               mem_ecode_we_b;
    logic [vaddr_w-1:0] mem_badv_a;
    logic [vaddr_w-1:0] mem_badv_b;
    logic               mem_badv_we_a;
    logic               mem_badv_we_b;
    logic [vaddr_w-1:0] mem_pc_a;
    logic [vaddr_w-1:0] mem_pc_b;
    logic               mem_ertn;

    logic [ecode_w-1:0] ecode;
    logic               ecode_we;
    logic [vaddr_w-1:0] badv;
    logic               badv_we;
    logic [vaddr_w-1:0] era;
    logic               era_we;
    logic               store_state;
    logic               restore_state;
    logic               flush_req;
    logic [vaddr_w-1:0] flush_req_pc;

    modport pipe (
        output mem_ecode_a, mem_ecode_b, mem_ecode_we_a, mem_ecode_we_b,
        output mem_badv_a, mem_badv_b, mem_badv_we_a, mem_badv_we_b,
        output mem_pc_a, mem_pc_b, mem_ertn,
        input  ecode, ecode_we, badv, badv_we, era, era_we,
        input  store_state, restore_state, flush_req, flush_req_pc
    );

    modport resolve (
        input  mem_ecode_a, mem_ecode_b, mem_ecode_we_a, mem_ecode_we_b,
        input  mem_badv_a, mem_badv_b, mem_badv_we_a, mem_badv_we_b,
        input  mem_pc_a, mem_pc_b, mem_ertn,
        output ecode, ecode_we, badv, badv_we, era, era_we,
        output store_state, restore_state, flush_req, flush_req_pc
    );
endinterface

// WB stage commit bundle
interface wb_csr_if;
    import csr_pkg::*;
    import excp_pkg::*;

    logic [csr_addr_w-1:0] csr_waddr;
    logic [csr_data_w-1:0] csr_we;      // Bit write mask
    logic [csr_data_w-1:0] csr_wdata;
    logic [ecode_w-1:0]    ecode;
    logic                  ecode_we;
    logic [vaddr_w-1:0]    badv;
    logic                  badv_we;
    logic [vaddr_w-1:0]    era;
    logic                  era_we;
    logic                  store_state;
    logic                  restore_state;
    logic                  flush;
    logic [vaddr_w-1:0]    flush_pc;

    modport pipe (
        output csr_waddr, csr_we, csr_wdata, ecode, ecode_we, badv, badv_we,
        output era, era_we, store_state, restore_state, flush, flush_pc
    );

    modport regfile (
        input  csr_waddr, csr_we, csr_wdata, ecode, ecode_we, badv, badv_we,
        input  era, era_we, store_state, restore_state, flush, flush_pc
    );
endinterface

// ==== src/csr_pipe_reg.sv ====
`timescale 1ns/1ns

module csr_pipe_reg (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            stall_dcache,
    input  logic                            stall_div,
    input  logic                            ex_br_a,       // Lane B is wrong-path
    input  logic [csr_pkg::csr_addr_w-1:0]  ex_csr_waddr,
    input  logic [csr_pkg::csr_data_w-1:0]  ex_csr_we,
    input  logic [csr_pkg::csr_data_w-1:0]  ex_csr_wdata,
    input  logic                            ex_ertn,
    input  logic [excp_pkg::ecode_w-1:0]    ex_ecode_a,
    input  logic [excp_pkg::ecode_w-1:0]    ex_ecode_b,
    input  logic                            ex_ecode_we_a,
    input  logic                            ex_ecode_we_b,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_badv_a,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_badv_b,
    input  logic                            ex_badv_we_a,
    input  logic                            ex_badv_we_b,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_pc_a,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_pc_b,
    mem_excp_if.pipe                        mem,
    wb_csr_if.pipe                          wb
);
    import csr_pkg::*;
    import excp_pkg::*;

    logic [csr_addr_w-1:0] mem_csr_waddr;
    logic [csr_data_w-1:0] mem_csr_we;
    logic [csr_data_w-1:0] mem_csr_wdata;

    logic advance;
    logic mem_load;
    logic mem_kill;
    logic wb_load;
    logic ex_has_excp;

    assign advance     = !stall_dcache && !stall_div;
    assign mem_load    = wb.flush || advance;    // Flush overrides the stall
    assign mem_kill    = wb.flush || ex_br_a;
    assign wb_load     = wb.flush || advance;
    assign ex_has_excp = (ex_ecode_a != ecode_none) || (ex_ecode_b != ecode_none);

    // EX to MEM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_csr_waddr      <= '0;
            mem_csr_we         <= '0;
            mem_csr_wdata      <= '0;
            mem.mem_ertn       <= 1'b0;
            mem.mem_ecode_a    <= '0;
            mem.mem_ecode_b    <= '0;
            mem.mem_ecode_we_a <= 1'b0;
            mem.mem_ecode_we_b <= 1'b0;
            mem.mem_badv_a     <= '0;
            mem.mem_badv_b     <= '0;
            mem.mem_badv_we_a  <= 1'b0;
            mem.mem_badv_we_b  <= 1'b0;
            mem.mem_pc_a       <= '0;
            mem.mem_pc_b       <= '0;
        end else if (mem_load) begin
            mem_csr_waddr      <= mem_kill ? '0 : ex_csr_waddr;
            mem_csr_we         <= mem_kill ? '0 : ex_csr_we;
            mem_csr_wdata      <= mem_kill ? '0 : ex_csr_wdata;
            mem.mem_ertn       <= mem_kill ? 1'b0 : (ex_ertn && !ex_has_excp);
            mem.mem_ecode_a    <= mem_kill ? '0 : ex_ecode_a;
            mem.mem_ecode_b    <= mem_kill ? '0 : ex_ecode_b;
            mem.mem_ecode_we_a <= mem_kill ? 1'b0 : ex_ecode_we_a;
            mem.mem_ecode_we_b <= mem_kill ? 1'b0 : ex_ecode_we_b;
            mem.mem_badv_a     <= mem_kill ? '0 : ex_badv_a;
            mem.mem_badv_b     <= mem_kill ? '0 : ex_badv_b;
            mem.mem_badv_we_a  <= mem_kill ? 1'b0 : ex_badv_we_a;
            mem.mem_badv_we_b  <= mem_kill ? 1'b0 : ex_badv_we_b;
            mem.mem_pc_a       <= mem_kill ? '0 : ex_pc_a;
            mem.mem_pc_b       <= mem_kill ? '0 : ex_pc_b;
        end
    end

    // MEM to WB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.csr_waddr     <= '0;
            wb.csr_we        <= '0;
            wb.csr_wdata     <= '0;
            wb.ecode         <= '0;
            wb.ecode_we      <= 1'b0;
            wb.badv          <= '0;
            wb.badv_we       <= 1'b0;
            wb.era           <= '0;
            wb.era_we        <= 1'b0;
            wb.store_state   <= 1'b0;
            wb.restore_state <= 1'b0;
            wb.flush         <= 1'b0;
            wb.flush_pc      <= '0;
        end else if (wb_load) begin
            wb.csr_waddr     <= wb.flush ? '0 : mem_csr_waddr;
            wb.csr_we        <= (wb.flush || mem.ecode != ecode_none) ? '0 : mem_csr_we;
            wb.csr_wdata     <= wb.flush ? '0 : mem_csr_wdata;
            wb.ecode         <= wb.flush ? '0 : mem.ecode;
            wb.ecode_we      <= wb.flush ? 1'b0 : mem.ecode_we;
            wb.badv          <= wb.flush ? '0 : mem.badv;
            wb.badv_we       <= wb.flush ? 1'b0 : mem.badv_we;
            wb.era           <= wb.flush ? '0 : mem.era;
            wb.era_we        <= wb.flush ? 1'b0 : mem.era_we;
            wb.store_state   <= wb.flush ? 1'b0 : mem.store_state;
            wb.restore_state <= wb.flush ? 1'b0 : mem.restore_state;
            wb.flush         <= wb.flush ? 1'b0 : mem.flush_req;
            wb.flush_pc      <= wb.flush ? '0 : mem.flush_req_pc;
        end else begin
            // Stalled, the regfile already took this bundle
            wb.csr_we        <= '0;
            wb.ecode_we      <= 1'b0;
            wb.badv_we       <= 1'b0;
            wb.era_we        <= 1'b0;
            wb.store_state   <= 1'b0;
            wb.restore_state <= 1'b0;
        end
    end

    // Faulting bundles never reach the CSR write port
    assert property (@(posedge clk) disable iff (!arst_n) wb.ecode_we |-> wb.csr_we == '0)
        else $error("WB CSR write mask set together with an exception");

endmodule

// ==== src/excp_resolve.sv ====
`timescale 1ns/1ns

module excp_resolve #(
    parameter logic [csr_pkg::csr_data_w-1:0] reset_eentry = '0
) (
    mem_excp_if.resolve                     mem,
    input  logic [csr_pkg::csr_data_w-1:0]  cur_era,
    input  logic [csr_pkg::csr_data_w-1:0]  cur_eentry
);
    import excp_pkg::*;

    logic               excp_a;
    logic               excp_b;
    logic               take_b;     // Lane B only when lane A is clean
    logic               any_excp;
    logic [ecode_w-1:0] sel_ecode;
    logic [vaddr_w-1:0] sel_badv;
    logic               sel_badv_we;
    logic [vaddr_w-1:0] sel_pc;

    // Instruction addresses are word aligned
    if (reset_eentry[1:0] != 2'b00) begin : g_bad_entry
        $error("reset_eentry is not word aligned");
    end

    assign excp_a   = mem.mem_ecode_we_a && (mem.mem_ecode_a != ecode_none);
    assign excp_b   = mem.mem_ecode_we_b && (mem.mem_ecode_b != ecode_none);
    assign take_b   = !excp_a && excp_b;
    assign any_excp = excp_a || excp_b;

    assign sel_ecode   = take_b ? mem.mem_ecode_b : mem.mem_ecode_a;
    assign sel_badv    = take_b ? mem.mem_badv_b : mem.mem_badv_a;
    assign sel_badv_we = take_b ? mem.mem_badv_we_b : mem.mem_badv_we_a;
    assign sel_pc      = take_b ? mem.mem_pc_b : mem.mem_pc_a;

    always_comb begin
        mem.ecode         = ecode_none;
        mem.ecode_we      = 1'b0;
        mem.badv          = '0;
        mem.badv_we       = 1'b0;
        mem.era           = '0;
        mem.era_we        = 1'b0;
        mem.store_state   = 1'b0;
        mem.restore_state = 1'b0;
        mem.flush_req     = 1'b0;
        mem.flush_req_pc  = '0;
        if (any_excp) begin
            mem.ecode        = sel_ecode;
            mem.ecode_we     = 1'b1;
            mem.badv         = sel_badv;
            mem.badv_we      = sel_badv_we;
            mem.era          = sel_pc;
            mem.era_we       = 1'b1;
            mem.store_state  = 1'b1;
            mem.flush_req    = 1'b1;
            mem.flush_req_pc = cur_eentry;      // Jump to the handler
        end else if (mem.mem_ertn) begin
            mem.restore_state = 1'b1;
            mem.flush_req     = 1'b1;
            mem.flush_req_pc  = cur_era;
        end
    end

    // Pipe drops ertn from faulting pairs so entry and return never meet
    always_comb begin
        assert final (!(mem.mem_ertn && any_excp))
            else $error("store_state and restore_state requested together");
    end

endmodule

// ==== src/csr_regfile.sv ====
`timescale 1ns/1ns

module csr_regfile #(
    parameter logic [csr_pkg::csr_data_w-1:0] reset_eentry = '0
) (
    input  logic                            clk,
    input  logic                            arst_n,
    wb_csr_if.regfile                       wb,
    input  logic [csr_pkg::csr_addr_w-1:0]  csr_raddr,
    output logic [csr_pkg::csr_data_w-1:0]  csr_rdata,
    output logic [csr_pkg::csr_data_w-1:0]  cur_era,
    output logic [csr_pkg::csr_data_w-1:0]  cur_eentry
);
    import csr_pkg::*;
    import excp_pkg::*;

    logic [csr_data_w-1:0] crmd;
    logic [csr_data_w-1:0] prmd;
    logic [csr_data_w-1:0] estat;
    logic [csr_data_w-1:0] era;
    logic [csr_data_w-1:0] badv;
    logic [csr_data_w-1:0] eentry;
    logic [csr_data_w-1:0] save0;

    function automatic logic [csr_data_w-1:0] masked(
        input logic [csr_data_w-1:0] old_val,
        input logic [csr_data_w-1:0] new_val,
        input logic [csr_data_w-1:0] mask
    );
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd   <= '0;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            badv   <= '0;
            eentry <= reset_eentry;
            save0  <= '0;
        end else begin
            // Software write, only masked bits change
            case (wb.csr_waddr)
                csr_crmd:   crmd   <= masked(crmd, wb.csr_wdata, wb.csr_we);
                csr_prmd:   prmd   <= masked(prmd, wb.csr_wdata, wb.csr_we);
                csr_estat:  estat  <= masked(estat, wb.csr_wdata, wb.csr_we);
                csr_era:    era    <= masked(era, wb.csr_wdata, wb.csr_we);
                csr_badv:   badv   <= masked(badv, wb.csr_wdata, wb.csr_we);
                csr_eentry: eentry <= masked(eentry, wb.csr_wdata, wb.csr_we);
                csr_save0:  save0  <= masked(save0, wb.csr_wdata, wb.csr_we);
                default: ;
            endcase

            // Exception entry drops to PLV0 with interrupts off
            if (wb.store_state) begin
                prmd[prmd_pplv_lsb +: plv_w] <= crmd[crmd_plv_lsb +: plv_w];
                prmd[prmd_pie_bit]           <= crmd[crmd_ie_bit];
                crmd[crmd_plv_lsb +: plv_w]  <= '0;
                crmd[crmd_ie_bit]            <= 1'b0;
            end
            if (wb.restore_state) begin
                crmd[crmd_plv_lsb +: plv_w] <= prmd[prmd_pplv_lsb +: plv_w];
                crmd[crmd_ie_bit]           <= prmd[prmd_pie_bit];
            end

            if (wb.ecode_we) estat[estat_ecode_lsb +: ecode_w] <= wb.ecode;
            if (wb.era_we) era <= wb.era;
            if (wb.badv_we) badv <= wb.badv;
        end
    end

    always_comb begin
        case (csr_raddr)
            csr_crmd:   csr_rdata = crmd;
            csr_prmd:   csr_rdata = prmd;
            csr_estat:  csr_rdata = estat;
            csr_era:    csr_rdata = era;
            csr_badv:   csr_rdata = badv;
            csr_eentry: csr_rdata = eentry;
            csr_save0:  csr_rdata = save0;
            default:    csr_rdata = '0;   // Unimplemented
        endcase
    end

    assign cur_era    = era;
    assign cur_eentry = eentry;

    // MEM zeroes the write mask for any faulting bundle
    assert property (@(posedge clk) disable iff (!arst_n) wb.store_state |-> wb.csr_we == '0)
        else $error("CSR write in the same cycle as exception entry");

endmodule

// ==== src/csr_unit_top.sv ====
`timescale 1ns/1ns

module csr_unit_top #(
    parameter logic [csr_pkg::csr_data_w-1:0] reset_eentry = 32'h1c00_8000
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            stall_dcache,
    input  logic                            stall_div,
    input  logic                            ex_br_a,
    input  logic [csr_pkg::csr_addr_w-1:0]  ex_csr_waddr,
    input  logic [csr_pkg::csr_data_w-1:0]  ex_csr_we,
    input  logic [csr_pkg::csr_data_w-1:0]  ex_csr_wdata,
    input  logic                            ex_ertn,
    input  logic [excp_pkg::ecode_w-1:0]    ex_ecode_a,
    input  logic [excp_pkg::ecode_w-1:0]    ex_ecode_b,
    input  logic                            ex_ecode_we_a,
    input  logic                            ex_ecode_we_b,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_badv_a,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_badv_b,
    input  logic                            ex_badv_we_a,
    input  logic                            ex_badv_we_b,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_pc_a,
    input  logic [excp_pkg::vaddr_w-1:0]    ex_pc_b,
    input  logic [csr_pkg::csr_addr_w-1:0]  csr_raddr,
    output logic [csr_pkg::csr_data_w-1:0]  csr_rdata,
    output logic                            flush,
    output logic [excp_pkg::vaddr_w-1:0]    flush_pc
);
    import csr_pkg::*;

    logic [csr_data_w-1:0] cur_era;
    logic [csr_data_w-1:0] cur_eentry;

    mem_excp_if mem_if ();
    wb_csr_if   wb_if ();

    csr_pipe_reg u_pipe (
        .clk, .arst_n, .stall_dcache, .stall_div, .ex_br_a,
        .ex_csr_waddr, .ex_csr_we, .ex_csr_wdata, .ex_ertn,
        .ex_ecode_a, .ex_ecode_b, .ex_ecode_we_a, .ex_ecode_we_b,
        .ex_badv_a, .ex_badv_b, .ex_badv_we_a, .ex_badv_we_b,
        .ex_pc_a, .ex_pc_b,
        .mem (mem_if.pipe),
        .wb  (wb_if.pipe)
    );

    excp_resolve #(.reset_eentry(reset_eentry)) u_resolve (
        .mem        (mem_if.resolve),
        .cur_era    (cur_era),
        .cur_eentry (cur_eentry)
    );

    csr_regfile #(.reset_eentry(reset_eentry)) u_regfile (
        .clk, .arst_n,
        .wb         (wb_if.regfile),
        .csr_raddr  (csr_raddr),
        .csr_rdata  (csr_rdata),
        .cur_era    (cur_era),
        .cur_eentry (cur_eentry)
    );

    assign flush    = wb_if.flush;      // One-cycle redirect strobe
    assign flush_pc = wb_if.flush_pc;

endmodule

// ==== testbench/tb_csr_unit.sv ====
`timescale 1ns/1ns

module tb_csr_unit;
    import csr_pkg::*;
    import excp_pkg::*;

    localparam int drive_dly   = 10;
    localparam int flush_limit = 12;    // Cycles allowed for a redirect

    logic                  clk;
    logic                  arst_n;
    logic                  stall_dcache;
    logic                  stall_div;
    logic                  ex_br_a;
    logic [csr_addr_w-1:0] ex_csr_waddr;
    logic [csr_data_w-1:0] ex_csr_we;
    logic [csr_data_w-1:0] ex_csr_wdata;
    logic                  ex_ertn;
    logic [ecode_w-1:0]    ex_ecode_a;
    logic [ecode_w-1:0]    ex_ecode_b;
    logic                  ex_ecode_we_a;
    logic                  ex_ecode_we_b;
    logic [vaddr_w-1:0]    ex_badv_a;
    logic [vaddr_w-1:0]    ex_badv_b;
    logic                  ex_badv_we_a;
    logic                  ex_badv_we_b;
    logic [vaddr_w-1:0]    ex_pc_a;
    logic [vaddr_w-1:0]    ex_pc_b;
    logic [csr_addr_w-1:0] csr_raddr;
    logic [csr_data_w-1:0] csr_rdata;
    logic                  flush;
    logic [vaddr_w-1:0]    flush_pc;

    int                    flush_cnt;   // Redirect pulses seen in the current record
    logic [vaddr_w-1:0]    seen_pc;

    csr_unit_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_csr(input logic [csr_addr_w-1:0] addr,
                             input logic [csr_data_w-1:0] got,
                             input logic [csr_data_w-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch csr_rdata at 0x%h: got 0x%h, expected 0x%h",
                                      addr, got, exp));
    endtask

    task automatic check_flush(input logic got_flush, input logic [vaddr_w-1:0] got_pc,
                               input logic exp_flush, input logic [vaddr_w-1:0] exp_pc);
        if (got_flush !== exp_flush)
            stop_with_error($sformatf("Mismatch flush: got 0x%h, expected 0x%h",
                                      got_flush, exp_flush));
        if (exp_flush && got_pc !== exp_pc)
            stop_with_error($sformatf("Mismatch flush_pc: got 0x%h, expected 0x%h",
                                      got_pc, exp_pc));
    endtask

    task automatic clear_bundle();
        ex_br_a       = 1'b0;
        ex_csr_waddr  = '0;
        ex_csr_we     = '0;
        ex_csr_wdata  = '0;
        ex_ertn       = 1'b0;
        ex_ecode_a    = '0;
        ex_ecode_b    = '0;
        ex_ecode_we_a = 1'b0;
        ex_ecode_we_b = 1'b0;
        ex_badv_a     = '0;
        ex_badv_b     = '0;
        ex_badv_we_a  = 1'b0;
        ex_badv_we_b  = 1'b0;
        ex_pc_a       = '0;
        ex_pc_b       = '0;
    endtask

    // 1 holds the dcache stall, 2 the divider stall
    task automatic set_stall(input logic [1:0] stall_sel);
        stall_dcache = (stall_sel == 2'd1);
        stall_div    = (stall_sel == 2'd2);
    endtask

    task automatic idle_cycle(input logic [1:0] stall_sel);
        @(posedge clk);
        #drive_dly;
        clear_bundle();
        set_stall(stall_sel);
        if (flush === 1'b1) begin
            flush_cnt++;
            seen_pc = flush_pc;
        end
    endtask

    initial begin
        int                    fd;
        int                    cnt;
        int                    cycles;
        int                    n_rec;
        logic [8*128-1:0]      skip_buf;
        logic [7:0]            kind;
        logic [csr_addr_w-1:0] waddr;
        logic [csr_data_w-1:0] mask;
        logic [csr_data_w-1:0] wdata;
        logic                  ertn;
        logic [ecode_w-1:0]    code_a;
        logic [ecode_w-1:0]    code_b;
        logic                  we_a;
        logic                  we_b;
        logic [vaddr_w-1:0]    badv_a;
        logic [vaddr_w-1:0]    badv_b;
        logic                  bwe_a;
        logic                  bwe_b;
        logic [vaddr_w-1:0]    pc_a;
        logic [1:0]            stall_sel;
        logic                  br_a;
        logic                  exp_flush;
        logic [vaddr_w-1:0]    exp_pc;
        logic [csr_addr_w-1:0] raddr;
        logic [csr_data_w-1:0] exp_data;

        arst_n    = 1'b0;
        csr_raddr = '0;
        flush_cnt = 0;
        seen_pc   = '0;
        clear_bundle();
        set_stall(2'd0);
        repeat (10) @(posedge clk);
        #drive_dly;
        arst_n = 1'b1;

        fd = $fopen("testbench/csr_unit_testdata.txt", "r");
        if (fd == 0)
            stop_with_error("Could not open the test data file");
        n_rec = 0;
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                cnt = $fgets(skip_buf, fd);
                continue;
            end
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          waddr, mask, wdata, ertn, code_a, we_a, badv_a, bwe_a, pc_a,
                          code_b, we_b, badv_b, bwe_b, stall_sel, br_a,
                          exp_flush, exp_pc, raddr, exp_data);
            n_rec++;
            if (cnt != 19 || !(kind == "c" || kind == "r" || kind == "m" || kind == "w"))
                stop_with_error($sformatf("Test data record %0d is malformed", n_rec));

            @(posedge clk);
            #drive_dly;
            ex_csr_waddr  = waddr;
            ex_csr_we     = mask;
            ex_csr_wdata  = wdata;
            ex_ertn       = ertn;
            ex_ecode_a    = code_a;
            ex_ecode_we_a = we_a;
            ex_badv_a     = badv_a;
            ex_badv_we_a  = bwe_a;
            ex_pc_a       = pc_a;
            ex_ecode_b    = code_b;
            ex_ecode_we_b = we_b;
            ex_badv_b     = badv_b;
            ex_badv_we_b  = bwe_b;
            ex_pc_b       = pc_a + 32'd4;     // Lane B is the next word
            ex_br_a       = br_a;
            set_stall((kind == "c" || kind == "r") ? stall_sel : 2'd0);
            flush_cnt = 0;

            if (kind == "w")
                idle_cycle(2'd0);    // Move it on to WB first
            if (kind == "m" || kind == "w")
                repeat (3) idle_cycle(stall_sel);

            cycles = 0;
            while (exp_flush ? (flush_cnt == 0) : (cycles < 4)) begin
                if (cycles == flush_limit)
                    stop_with_error($sformatf("No flush within %0d cycles in record %0d",
                                              flush_limit, n_rec));
                idle_cycle(2'd0);
                cycles++;
            end
            repeat (2) idle_cycle(2'd0);    // Commit edge and one more to catch a repeat
            check_flush(flush_cnt != 0, seen_pc, exp_flush, exp_pc);
            if (flush_cnt > 1)
                stop_with_error($sformatf("flush pulsed %0d times in record %0d",
                                          flush_cnt, n_rec));
            csr_raddr = raddr;
            #1;
            check_csr(raddr, csr_rdata, exp_data);
        end
        $fclose(fd);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== testbench/csr_unit_testdata.txt ====
# kind waddr mask wdata ertn | A: ecode we badv badv_we pc | B: ecode we badv badv_we
#   stall(1 dcache, 2 div) br_a | expect: flush flush_pc raddr rdata (lane B pc = A pc + 4)
# c/r: bundle with the stall on its own cycle; m: stall while in MEM; w: stall while in WB
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 00c 1c008000
c 030 ffffffff 12345678 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 030 12345678
c 030 0000ff00 aaaaaaaa 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 030 1234aa78
c 000 00000007 00000007 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 000 00000007
c 002 ffffffff deadbeef 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 002 00000000
c 00c 000000ff 00000040 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 00c 1c008040
c 000 00000000 00000000 0 09 1 0000abcd 1 1c000104 00 0 00000000 0 0 0 1 1c008040 005 00090000
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 007 0000abcd
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 001 00000007
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 000 00000000
c 000 00000000 00000000 1 00 0 00000000 0 00000000 00 0 00000000 0 0 0 1 1c000104 000 00000007
c 000 00000000 00000000 0 0d 1 00000000 0 1c000200 0c 1 00001111 1 0 0 1 1c008040 005 000d0000
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 007 0000abcd
c 000 00000000 00000000 1 00 0 00000000 0 00000000 00 0 00000000 0 0 0 1 1c000200 000 00000007
c 030 ffffffff 55555555 0 00 0 00000000 0 00000000 0e 1 00002222 1 0 1 0 00000000 030 1234aa78
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 006 1c000200
c 000 00000000 00000000 1 0c 1 00000000 0 1c000400 00 0 00000000 0 0 0 1 1c008040 005 000c0000
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 001 00000007
c 000 00000000 00000000 1 00 0 00000000 0 00000000 00 0 00000000 0 0 0 1 1c000400 000 00000007
c 030 ffffffff 99999999 0 00 0 00000000 0 00000000 00 0 00000000 0 1 0 0 00000000 030 1234aa78
c 000 00000000 00000000 0 08 1 00003333 1 1c000500 00 0 00000000 0 2 0 0 00000000 006 1c000400
m 000 00000000 00000000 0 08 1 00003333 1 1c000500 00 0 00000000 0 2 0 1 1c008040 007 00003333
r 000 00000000 00000000 0 00 0 00000000 0 00000000 00 0 00000000 0 0 0 0 00000000 001 00000007
c 000 00000000 00000000 1 00 0 00000000 0 00000000 00 0 00000000 0 0 0 1 1c000500 000 00000007
w 030 0000ffff 0000beef 0 00 0 00000000 0 00000000 00 0 00000000 0 1 0 0 00000000 030 1234beef
w 000 00000000 00000000 0 0b 1 00000000 0 1c000600 00 0 00000000 0 2 0 1 1c008040 001 00000007
c 000 00000000 00000000 1 00 0 00000000 0 00000000 00 0 00000000 0 0 0 1 1c000600 000 00000007
c 030 ffffffff 00000000 0 0d 1 00000000 0 1c000700 00 0 00000000 0 0 0 1 1c008040 030 1234beef
c 000 00000000 00000000 1 00 0 00000000 0 00000000 00 0 00000000 0 0 0 1 1c000700 000 00000007

// ==== build.f ====
src/csr_pkg.sv
src/excp_pkg.sv
src/csr_pipe_if.sv
src/csr_pipe_reg.sv
src/excp_resolve.sv
src/csr_regfile.sv
src/csr_unit_top.sv
testbench/tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/excp_pkg.sv
  - src/csr_pipe_if.sv
  - src/csr_pipe_reg.sv
  - src/excp_resolve.sv
  - src/csr_regfile.sv
  - src/csr_unit_top.sv
  - target: test
    files:
      - testbench/tb_csr_unit.sv
